// ==== lamp_params.svh ====
`ifndef LAMP_PARAMS_SVH
`define LAMP_PARAMS_SVH

// bytes per host frame
// mode, intensity, index, r, g, b, w
`define LAMP_FRAME_BYTES 7

// duty and pwm counter width
`define LAMP_PWM_BITS 8

// entries in the fixed colour table
`define LAMP_PALETTE_DEPTH 16

`endif

// ==== lamp_frame_pkg.sv ====
`include "lamp_params.svh"

package lamp_frame_pkg;

    // mode byte opcodes, anything else acts as off
    typedef enum logic [7:0] {
        MODE_OFF     = 8'd0,
        MODE_DIRECT  = 8'd1,
        MODE_PALETTE = 8'd2
    } lamp_mode_e;

    // byte position inside a frame, in wire order
    typedef enum logic [$clog2(`LAMP_FRAME_BYTES)-1:0] {
        FLD_MODE,
        FLD_LINT,
        FLD_INDEX,
        FLD_RED,
        FLD_GREEN,
        FLD_BLUE,
        FLD_WHITE
    } frame_field_e;

    // spi receiver
    typedef enum logic {
        SPI_IDLE,
        SPI_SHIFT
    } spi_state_e;

endpackage

// ==== lamp_color_pkg.sv ====
`include "lamp_params.svh"

package lamp_color_pkg;

    // one colour channel, also used as a pwm duty
    typedef logic [`LAMP_PWM_BITS-1:0] duty_t;

    // palette address, low nibble of the index byte
    typedef logic [$clog2(`LAMP_PALETTE_DEPTH)-1:0] palette_idx_t;

    // handy constants for the table
    localparam duty_t DUTY_MIN = '0;
    localparam duty_t DUTY_MAX = '1;

endpackage

// ==== spi_slave_rx.sv ====
`timescale 1ns/1ps
`include "lamp_params.svh"

module spi_slave_rx (
    input  logic                  clk12,
    input  logic                  rst,
    input  logic                  sck,
    input  logic                  cs,
    input  logic                  mosi,
    output lamp_color_pkg::duty_t rx_byte,
    output logic                  rx_rdy,
    output logic                  frame_start,
    output logic                  frame_abort
);

    // two sync flops plus one history flop for edges
    logic [2:0] sck_q;
    logic [2:0] cs_q;
    logic [1:0] mosi_q;

    logic sck_rise;
    logic cs_fall;
    logic cs_rise;

    lamp_frame_pkg::spi_state_e   state;
    lamp_color_pkg::duty_t        shift_reg;
    logic [$clog2(`LAMP_PWM_BITS)-1:0] bit_cnt;

    always_ff @(posedge clk12) begin
        if (rst) begin
            sck_q  <= '0;
            // cs idles high, avoids a false frame start
            cs_q   <= '1;
            mosi_q <= '0;
        end else begin
            sck_q  <= {sck_q[1:0], sck};
            cs_q   <= {cs_q[1:0], cs};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    // edge detect on the synchronized copies
    assign sck_rise = sck_q[1] & ~sck_q[2];
    assign cs_fall  = ~cs_q[1] & cs_q[2];
    assign cs_rise  = cs_q[1] & ~cs_q[2];

    always_ff @(posedge clk12) begin
        if (rst) begin
            state       <= lamp_frame_pkg::SPI_IDLE;
            bit_cnt     <= '0;
            rx_rdy      <= 1'b0;
            frame_start <= 1'b0;
            frame_abort <= 1'b0;
        end else begin
            rx_rdy      <= 1'b0;
            frame_start <= cs_fall;
            frame_abort <= cs_rise;
            case (state)
                lamp_frame_pkg::SPI_IDLE: begin
                    if (cs_fall) begin
                        // new frame, restart byte alignment
                        bit_cnt <= '0;
                        state   <= lamp_frame_pkg::SPI_SHIFT;
                    end
                end
                lamp_frame_pkg::SPI_SHIFT: begin
                    if (cs_rise) begin
                        state <= lamp_frame_pkg::SPI_IDLE;
                    end else if (sck_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        // last bit of the byte, counter wraps by itself
                        if (bit_cnt == '1) begin
                            rx_rdy <= 1'b1;
                        end
                    end
                end
                default: state <= lamp_frame_pkg::SPI_IDLE;
            endcase
        end
    end

    // data path, msb first
    always_ff @(posedge clk12) begin
        if (state == lamp_frame_pkg::SPI_SHIFT && sck_rise) begin
            shift_reg <= {shift_reg[`LAMP_PWM_BITS-2:0], mosi_q[1]};
            if (bit_cnt == '1) begin
                rx_byte <= {shift_reg[`LAMP_PWM_BITS-2:0], mosi_q[1]};
            end
        end
    end

endmodule

// ==== frame_dispenser.sv ====
`timescale 1ns/1ps
`include "lamp_params.svh"

module frame_dispenser (
    input  logic                         clk12,
    input  logic                         rst,
    input  lamp_color_pkg::duty_t        rx_byte,
    input  logic                         rx_rdy,
    input  logic                         frame_start,
    input  logic                         frame_abort,
    output logic [7:0]                   mode,
    output lamp_color_pkg::duty_t        lint,
    output lamp_color_pkg::palette_idx_t color_idx,
    output lamp_color_pkg::duty_t        red,
    output lamp_color_pkg::duty_t        green,
    output lamp_color_pkg::duty_t        blue,
    output lamp_color_pkg::duty_t        white,
    output logic                         commit
);

    localparam lamp_frame_pkg::frame_field_e LAST_FIELD =
        lamp_frame_pkg::frame_field_e'(`LAMP_FRAME_BYTES - 1);

    lamp_frame_pkg::frame_field_e state;
    // set between frame_start and the last byte or an abort
    logic active;

    // shadow copies, filled byte by byte
    logic [7:0]                   mode_sh;
    lamp_color_pkg::duty_t        lint_sh;
    lamp_color_pkg::palette_idx_t idx_sh;
    lamp_color_pkg::duty_t        red_sh;
    lamp_color_pkg::duty_t        green_sh;
    lamp_color_pkg::duty_t        blue_sh;

    always_ff @(posedge clk12) begin
        if (rst) begin
            state  <= lamp_frame_pkg::FLD_MODE;
            active <= 1'b0;
            commit <= 1'b0;
        end else begin
            commit <= 1'b0;
            if (frame_start) begin
                state  <= lamp_frame_pkg::FLD_MODE;
                active <= 1'b1;
            end else if (frame_abort) begin
                // short frame, shadows simply never get copied
                active <= 1'b0;
            end else if (active && rx_rdy) begin
                if (state == LAST_FIELD) begin
                    active <= 1'b0;
                    commit <= 1'b1;
                end else begin
                    state <= lamp_frame_pkg::frame_field_e'(state + 1'b1);
                end
            end
        end
    end

    // byte steering into shadows
    always_ff @(posedge clk12) begin
        if (active && rx_rdy && !frame_start && !frame_abort) begin
            case (state)
                lamp_frame_pkg::FLD_MODE:  mode_sh  <= rx_byte;
                lamp_frame_pkg::FLD_LINT:  lint_sh  <= rx_byte;
                // upper nibble dropped
                lamp_frame_pkg::FLD_INDEX: idx_sh   <= rx_byte[3:0];
                lamp_frame_pkg::FLD_RED:   red_sh   <= rx_byte;
                lamp_frame_pkg::FLD_GREEN: green_sh <= rx_byte;
                lamp_frame_pkg::FLD_BLUE:  blue_sh  <= rx_byte;
                default: ;
            endcase
        end
    end

    // all fields move together, white straight from the last byte
    always_ff @(posedge clk12) begin
        if (rst) begin
            mode      <= lamp_frame_pkg::MODE_OFF;
            lint      <= '0;
            color_idx <= '0;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
            white     <= '0;
        end else if (active && rx_rdy && !frame_start && !frame_abort
                     && state == LAST_FIELD) begin
            mode      <= mode_sh;
            lint      <= lint_sh;
            color_idx <= idx_sh;
            red       <= red_sh;
            green     <= green_sh;
            blue      <= blue_sh;
            white     <= rx_byte;
        end
    end

endmodule

// ==== palette_lookup.sv ====
`timescale 1ns/1ps

module palette_lookup (
    input  logic                         clk12,
    input  logic                         rst,
    input  lamp_color_pkg::palette_idx_t color_idx,
    output lamp_color_pkg::duty_t        pal_red,
    output lamp_color_pkg::duty_t        pal_green,
    output lamp_color_pkg::duty_t        pal_blue,
    output lamp_color_pkg::duty_t        pal_white
);

    // one rgbw word per entry, red in the top byte
    logic [31:0] entry;

    always_comb begin
        case (color_idx)
            4'd0:  entry = 32'h00_00_00_00; // black
            4'd1:  entry = 32'hff_00_00_00; // red
            4'd2:  entry = 32'h00_ff_00_00; // green
            4'd3:  entry = 32'h00_00_ff_00; // blue
            4'd4:  entry = 32'hff_ff_00_00; // yellow
            4'd5:  entry = 32'h00_ff_ff_00; // cyan
            4'd6:  entry = 32'hff_00_ff_00; // magenta
            4'd7:  entry = 32'h00_00_00_ff; // white led only
            4'd8:  entry = 32'hff_60_10_c0; // warm white
            4'd9:  entry = 32'h40_60_ff_c0; // cold white
            4'd10: entry = 32'hff_80_00_00; // orange
            4'd11: entry = 32'h80_00_ff_00; // violet
            4'd12: entry = 32'h80_ff_00_00; // lime
            4'd13: entry = 32'hff_40_80_20; // pink
            4'd14: entry = 32'h20_20_20_20; // dim grey
            4'd15: entry = 32'hff_ff_ff_ff; // everything on
            default: entry = 32'h00_00_00_00;
        endcase
    end

    always_ff @(posedge clk12) begin
        if (rst) begin
            pal_red   <= lamp_color_pkg::DUTY_MIN;
            pal_green <= lamp_color_pkg::DUTY_MIN;
            pal_blue  <= lamp_color_pkg::DUTY_MIN;
            pal_white <= lamp_color_pkg::DUTY_MIN;
        end else begin
            pal_red   <= entry[31:24];
            pal_green <= entry[23:16];
            pal_blue  <= entry[15:8];
            pal_white <= entry[7:0];
        end
    end

endmodule

// ==== color_mixer.sv ====
`timescale 1ns/1ps
`include "lamp_params.svh"

module color_mixer (
    input  logic                  clk12,
    input  logic                  rst,
    input  logic                  commit,
    input  logic [7:0]            mode,
    input  lamp_color_pkg::duty_t lint,
    input  lamp_color_pkg::duty_t red,
    input  lamp_color_pkg::duty_t green,
    input  lamp_color_pkg::duty_t blue,
    input  lamp_color_pkg::duty_t white,
    input  lamp_color_pkg::duty_t pal_red,
    input  lamp_color_pkg::duty_t pal_green,
    input  lamp_color_pkg::duty_t pal_blue,
    input  lamp_color_pkg::duty_t pal_white,
    output lamp_color_pkg::duty_t duty_red,
    output lamp_color_pkg::duty_t duty_green,
    output lamp_color_pkg::duty_t duty_blue,
    output lamp_color_pkg::duty_t duty_white
);

    // palette is one cycle behind the frame fields
    logic commit_d;
    // lint + 1, so 255 means unity gain
    logic [`LAMP_PWM_BITS:0] gain;

    lamp_color_pkg::duty_t src_red;
    lamp_color_pkg::duty_t src_green;
    lamp_color_pkg::duty_t src_blue;
    lamp_color_pkg::duty_t src_white;

    // v * gain, keep the upper byte
    function automatic lamp_color_pkg::duty_t scale(
        input lamp_color_pkg::duty_t   v,
        input logic [`LAMP_PWM_BITS:0] g
    );
        logic [2*`LAMP_PWM_BITS-1:0] prod;
        begin
            prod = v * g;
            return prod[2*`LAMP_PWM_BITS-1:`LAMP_PWM_BITS];
        end
    endfunction

    assign gain = {1'b0, lint} + 1'b1;

    // source select, unknown modes fall to black
    always_comb begin
        case (lamp_frame_pkg::lamp_mode_e'(mode))
            lamp_frame_pkg::MODE_DIRECT: begin
                src_red   = red;
                src_green = green;
                src_blue  = blue;
                src_white = white;
            end
            lamp_frame_pkg::MODE_PALETTE: begin
                src_red   = pal_red;
                src_green = pal_green;
                src_blue  = pal_blue;
                src_white = pal_white;
            end
            default: begin
                src_red   = lamp_color_pkg::DUTY_MIN;
                src_green = lamp_color_pkg::DUTY_MIN;
                src_blue  = lamp_color_pkg::DUTY_MIN;
                src_white = lamp_color_pkg::DUTY_MIN;
            end
        endcase
    end

    always_ff @(posedge clk12) begin
        if (rst) begin
            commit_d   <= 1'b0;
            duty_red   <= '0;
            duty_green <= '0;
            duty_blue  <= '0;
            duty_white <= '0;
        end else begin
            commit_d <= commit;
            // duties land two cycles after commit
            if (commit_d) begin
                duty_red   <= scale(src_red, gain);
                duty_green <= scale(src_green, gain);
                duty_blue  <= scale(src_blue, gain);
                duty_white <= scale(src_white, gain);
            end
        end
    end

endmodule

// ==== pwm_gen.sv ====
`timescale 1ns/1ps

module pwm_gen (
    input  logic                  clk12,
    input  logic                  rst,
    input  lamp_color_pkg::duty_t duty_red,
    input  lamp_color_pkg::duty_t duty_green,
    input  lamp_color_pkg::duty_t duty_blue,
    input  lamp_color_pkg::duty_t duty_white,
    output logic                  red_pin,
    output logic                  green_pin,
    output logic                  blue_pin,
    output logic                  white_pin
);

    // shared period counter, 0..255
    lamp_color_pkg::duty_t cnt;
    // duties held for a whole period, r g b w
    lamp_color_pkg::duty_t lat [4];
    lamp_color_pkg::duty_t duty_in [4];
    logic [3:0]            pin_q;

    assign duty_in[0] = duty_red;
    assign duty_in[1] = duty_green;
    assign duty_in[2] = duty_blue;
    assign duty_in[3] = duty_white;

    always_ff @(posedge clk12) begin
        if (rst) begin
            cnt   <= '0;
            lat   <= '{default: '0};
            pin_q <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            for (int i = 0; i < 4; i++) begin
                // new duties take effect as cnt wraps to 0
                if (cnt == lamp_color_pkg::DUTY_MAX) begin
                    lat[i] <= duty_in[i];
                end
                // high for exactly lat cycles per period
                pin_q[i] <= (cnt < lat[i]);
            end
        end
    end

    assign red_pin   = pin_q[0];
    assign green_pin = pin_q[1];
    assign blue_pin  = pin_q[2];
    assign white_pin = pin_q[3];

endmodule

// ==== rgbw_lamp.sv ====
`timescale 1ns/1ps

module rgbw_lamp (
    input  logic clk12,
    input  logic rst,
    input  logic sck,
    input  logic mosi,
    input  logic cs,
    output logic red_pin,
    output logic green_pin,
    output logic blue_pin,
    output logic white_pin
);

    // receiver to dispenser
    lamp_color_pkg::duty_t rx_byte;
    logic rx_rdy;
    logic frame_start;
    logic frame_abort;

    // committed frame fields
    logic [7:0]                   mode;
    lamp_color_pkg::duty_t        lint;
    lamp_color_pkg::palette_idx_t color_idx;
    lamp_color_pkg::duty_t        red;
    lamp_color_pkg::duty_t        green;
    lamp_color_pkg::duty_t        blue;
    lamp_color_pkg::duty_t        white;
    logic                         commit;

    // palette colour
    lamp_color_pkg::duty_t pal_red;
    lamp_color_pkg::duty_t pal_green;
    lamp_color_pkg::duty_t pal_blue;
    lamp_color_pkg::duty_t pal_white;

    // mixer to pwm
    lamp_color_pkg::duty_t duty_red;
    lamp_color_pkg::duty_t duty_green;
    lamp_color_pkg::duty_t duty_blue;
    lamp_color_pkg::duty_t duty_white;

    spi_slave_rx u_spi_rx (
        .clk12       (clk12),
        .rst         (rst),
        .sck         (sck),
        .cs          (cs),
        .mosi        (mosi),
        .rx_byte     (rx_byte),
        .rx_rdy      (rx_rdy),
        .frame_start (frame_start),
        .frame_abort (frame_abort)
    );

    frame_dispenser u_dispenser (
        .clk12       (clk12),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_rdy      (rx_rdy),
        .frame_start (frame_start),
        .frame_abort (frame_abort),
        .mode        (mode),
        .lint        (lint),
        .color_idx   (color_idx),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .white       (white),
        .commit      (commit)
    );

    palette_lookup u_palette (
        .clk12     (clk12),
        .rst       (rst),
        .color_idx (color_idx),
        .pal_red   (pal_red),
        .pal_green (pal_green),
        .pal_blue  (pal_blue),
        .pal_white (pal_white)
    );

    color_mixer u_mixer (
        .clk12      (clk12),
        .rst        (rst),
        .commit     (commit),
        .mode       (mode),
        .lint       (lint),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .white      (white),
        .pal_red    (pal_red),
        .pal_green  (pal_green),
        .pal_blue   (pal_blue),
        .pal_white  (pal_white),
        .duty_red   (duty_red),
        .duty_green (duty_green),
        .duty_blue  (duty_blue),
        .duty_white (duty_white)
    );

    pwm_gen u_pwm (
        .clk12      (clk12),
        .rst        (rst),
        .duty_red   (duty_red),
        .duty_green (duty_green),
        .duty_blue  (duty_blue),
        .duty_white (duty_white),
        .red_pin    (red_pin),
        .green_pin  (green_pin),
        .blue_pin   (blue_pin),
        .white_pin  (white_pin)
    );

endmodule

// ==== rgbw_lamp_props.sv ====
`timescale 1ns/1ps

module rgbw_lamp_props (
    input logic clk12,
    input logic rst,
    input logic cs,
    input logic rx_rdy,
    input logic commit,
    input logic red_pin,
    input logic green_pin,
    input logic blue_pin,
    input logic white_pin
);

    // pins come out of reset low
    pins_low_after_reset: assert property (@(posedge clk12)
        rst |=> !(red_pin | green_pin | blue_pin | white_pin))
        else $error("pwm pins not low in the cycle after reset");

    // one strobe per received byte
    rx_rdy_single_cycle: assert property (@(posedge clk12) disable iff (rst)
        rx_rdy |=> !rx_rdy)
        else $error("rx_rdy high for two cycles in a row");

    // full frames commit while cs is still held low
    no_commit_cs_high: assert property (@(posedge clk12) disable iff (rst)
        commit |-> !cs)
        else $error("commit fired with cs high");

endmodule

bind rgbw_lamp rgbw_lamp_props u_props (
    .clk12     (clk12),
    .rst       (rst),
    .cs        (cs),
    .rx_rdy    (rx_rdy),
    .commit    (commit),
    .red_pin   (red_pin),
    .green_pin (green_pin),
    .blue_pin  (blue_pin),
    .white_pin (white_pin)
);

// ==== tb_rgbw_lamp.sv ====
`timescale 1ns/1ps
`include "lamp_params.svh"

module tb_rgbw_lamp;

    // sck half period in clk12 cycles, sck = clk12 / 8
    localparam int SPI_HALF      = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int SETTLE_CYCLES = 600;
    localparam int WINDOW_CYCLES = 256;
    localparam int MAX_GAP       = 15;
    // cs lead, every bit of a full frame, cs trail
    localparam int FRAME_CYCLES  = 4 * SPI_HALF + `LAMP_FRAME_BYTES * 8 * 2 * SPI_HALF;
    localparam int VECTOR_CYCLES = FRAME_CYCLES + MAX_GAP + SETTLE_CYCLES + WINDOW_CYCLES;

    logic clk12;
    logic rst;
    logic sck;
    logic cs;
    logic mosi;
    logic red_pin;
    logic green_pin;
    logic blue_pin;
    logic white_pin;

    // vectors, flattened: 7 frame bytes and 4 duties per entry
    int         vec_num [$];
    int         vec_len [$];
    logic [7:0] vec_frame [$];
    logic [7:0] vec_exp [$];
    bit         vectors_ready;

    int tests_run;
    int tests_failed;
    int other_errors;
    bit test_ok;

    rgbw_lamp UUT (
        .clk12     (clk12),
        .rst       (rst),
        .sck       (sck),
        .mosi      (mosi),
        .cs        (cs),
        .red_pin   (red_pin),
        .green_pin (green_pin),
        .blue_pin  (blue_pin),
        .white_pin (white_pin)
    );

    initial clk12 = 1'b0;
    always #10 clk12 = ~clk12;

    // next drive slot, just after the rising edge
    task automatic tick();
        @(posedge clk12);
        #2;
    endtask

    task automatic read_vectors(output bit ok);
        int    fd;
        int    n;
        int    t;
        int    len;
        int    j;
        int    f [7];
        int    e [4];
        string line;
        begin
            ok = 1'b0;
            fd = $fopen("lamp_input.txt", "r");
            if (fd == 0) begin
                $display("could not open lamp_input.txt for reading");
                return;
            end
            while ($fgets(line, fd) != 0) begin
                // skip comments and empty lines
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %h %h %h %h %h %h %h %d %h %h %h %h",
                            t, f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                            len, e[0], e[1], e[2], e[3]);
                if (n != 13) begin
                    $display("malformed vector line skipped: %s", line);
                    other_errors++;
                end else begin
                    vec_num.push_back(t);
                    vec_len.push_back(len);
                    for (j = 0; j < 7; j++) begin
                        vec_frame.push_back(f[j][7:0]);
                    end
                    for (j = 0; j < 4; j++) begin
                        vec_exp.push_back(e[j][7:0]);
                    end
                end
            end
            $fclose(fd);
            ok = (vec_num.size() > 0);
        end
    endtask

    // mode 0, msb first, mosi set while sck is low
    task automatic spi_byte(input logic [7:0] b);
        int i;
        begin
            for (i = 7; i >= 0; i--) begin
                mosi = b[i];
                repeat (SPI_HALF) tick();
                sck = 1'b1;
                repeat (SPI_HALF) tick();
                sck = 1'b0;
            end
        end
    endtask

    // nbytes below 7 gives a short frame
    task automatic send_frame(input int base, input int nbytes);
        int k;
        begin
            cs = 1'b0;
            repeat (2 * SPI_HALF) tick();
            for (k = 0; k < nbytes; k++) begin
                spi_byte(vec_frame[base + k]);
            end
            repeat (SPI_HALF) tick();
            cs = 1'b1;
            repeat (SPI_HALF) tick();
        end
    endtask

    // high cycles over one full pwm period, sampled mid cycle
    task automatic count_high(output int hr, output int hg, output int hb, output int hw);
        begin
            hr = 0;
            hg = 0;
            hb = 0;
            hw = 0;
            repeat (WINDOW_CYCLES) begin
                @(negedge clk12);
                hr += int'(red_pin);
                hg += int'(green_pin);
                hb += int'(blue_pin);
                hw += int'(white_pin);
            end
            tick();
        end
    endtask

    task automatic check_count(input string pin, input int expected, input int measured);
        assert (measured == expected) else begin
            $display("Fail %0t: %s expected %0d measured %0d", $time, pin, expected, measured);
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input int num);
        tests_run++;
        if (test_ok) begin
            $display("test %0d: ok", num);
        end else begin
            tests_failed++;
            $display("test %0d: mismatch on pwm high time", num);
        end
    endtask

    task automatic run_tests();
        int i;
        int gap;
        int hr;
        int hg;
        int hb;
        int hw;
        begin
            repeat (RESET_CYCLES) tick();
            rst = 1'b0;
            // test 0, pins quiet for a whole period after reset
            test_ok = 1'b1;
            count_high(hr, hg, hb, hw);
            check_count("red_pin", 0, hr);
            check_count("green_pin", 0, hg);
            check_count("blue_pin", 0, hb);
            check_count("white_pin", 0, hw);
            report_test(0);
            for (i = 0; i < vec_num.size(); i++) begin
                gap = $urandom % (MAX_GAP + 1);
                repeat (gap) tick();
                send_frame(i * 7, vec_len[i]);
                repeat (SETTLE_CYCLES) tick();
                test_ok = 1'b1;
                count_high(hr, hg, hb, hw);
                check_count("red_pin", int'(vec_exp[i * 4]), hr);
                check_count("green_pin", int'(vec_exp[i * 4 + 1]), hg);
                check_count("blue_pin", int'(vec_exp[i * 4 + 2]), hb);
                check_count("white_pin", int'(vec_exp[i * 4 + 3]), hw);
                report_test(vec_num[i]);
            end
        end
    endtask

    initial begin : main
        bit ok;
        sck          = 1'b0;
        cs           = 1'b1;
        mosi         = 1'b0;
        rst          = 1'b1;
        tests_run    = 0;
        tests_failed = 0;
        other_errors = 0;
        test_ok      = 1'b1;
        void'($urandom(32'h9170_077d));
        read_vectors(ok);
        if (!ok) begin
            $display("no usable vectors in lamp_input.txt, run stopped");
            $display("** FAIL **");
            $finish;
        end else begin
            vectors_ready = 1'b1;
            run_tests();
            $display("tests run %0d, failed %0d, other errors %0d",
                     tests_run, tests_failed, other_errors);
            if (tests_failed == 0 && other_errors == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    // budget per vector plus slack for reset and the first window
    initial begin : watchdog
        wait (vectors_ready);
        repeat (vec_num.size() * VECTOR_CYCLES + 1000) @(posedge clk12);
        $display("timeout: tests did not finish in the expected number of cycles");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== lamp_input.txt ====
# test mode lint index red green blue white bytes exp_red exp_green exp_blue exp_white
# test and bytes in decimal, everything else hex
1 01 ff 00 12 80 ff 00 7 12 80 ff 00
2 01 7f 00 ff 80 40 01 7 7f 40 20 00
3 01 00 00 ff ff ff ff 7 00 00 00 00
4 02 ff 01 11 22 33 44 7 ff 00 00 00
5 02 7f 38 11 22 33 44 7 7f 30 08 60
6 02 ff f9 00 00 00 00 7 40 60 ff c0
7 02 3f 0d 00 00 00 00 7 3f 10 20 08
8 02 bf 5a 00 00 00 00 7 bf 60 00 00
9 01 ff 00 aa 55 33 cc 7 aa 55 33 cc
10 00 ff 01 ff ff ff ff 7 00 00 00 00
11 01 ff 00 10 20 30 40 7 10 20 30 40
12 07 ff 0f ff ff ff ff 7 00 00 00 00
13 01 ff 00 21 43 65 87 7 21 43 65 87
14 01 ff 00 ff ff ff ff 4 21 43 65 87
15 02 ff 0f 00 00 00 00 7 ff ff ff ff

// ==== sim.f ====
+incdir+.
lamp_frame_pkg.sv
lamp_color_pkg.sv
spi_slave_rx.sv
frame_dispenser.sv
palette_lookup.sv
color_mixer.sv
pwm_gen.sv
rgbw_lamp.sv
rgbw_lamp_props.sv
tb_rgbw_lamp.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_rgbw_lamp
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = \*\* PASS \*\*

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^$(PASS_MSG)$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
